//--- logic/isaPkg.sv
/*
 * MIPS instruction set definitions
 * Instruction word views, the opcode and funct codes the core decodes,
 * and the ALU operation encoding
 */
`default_nettype none

package isaPkg;

  localparam int NUM_REGS = 32;

  typedef logic [4:0] regAddrT;

  // Only the opcodes this core implements
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDI  = 6'b001000,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_SLTIU = 6'b001011,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } functT;

  // SUB and SLT run the adder with operand B inverted
  typedef enum logic [2:0] {
    ALU_AND  = 3'b000,
    ALU_OR   = 3'b001,
    ALU_ADD  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_NOR  = 3'b101,
    ALU_SUB  = 3'b110,
    ALU_SLT  = 3'b111
  } aluOpT;

  typedef struct packed {
    opcodeT     op;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    logic [4:0] shamt;
    functT      funct;
  } rFieldsT;

  typedef struct packed {
    opcodeT      op;
    regAddrT     rs;
    regAddrT     rt;
    logic [15:0] imm;
  } iFieldsT;

  typedef struct packed {
    opcodeT      op;
    logic [25:0] target;
  } jFieldsT;

  // One fetched word read through whichever format applies
  typedef union packed {
    rFieldsT rFields;
    iFieldsT iFields;
    jFieldsT jFields;
  } instrWord;

endpackage

`default_nettype wire

//--- logic/pipePkg.sv
/*
 * Pipeline definitions
 * Control bundles and stage register layouts shared by the core
 * and the hazard logic
 */
`default_nettype none

package pipePkg;

  import isaPkg::*;

  localparam int WORD_WIDTH = 32;

  // Decode outputs, 8 bits
  typedef struct packed {
    logic  regWrite;
    logic  regDst;    // Write rd rather than rt
    logic  aluSrc;    // Operand B is the immediate
    logic  memWrite;
    logic  memToReg;
    aluOpT aluOp;
  } ctrlT;

  // ------------------------------
  // Control left after execute
  // ------------------------------
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic memToReg;
  } memCtrlT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
  } wbCtrlT;

  // Decode to execute register
  typedef struct packed {
    ctrlT                  ctrl;
    logic [WORD_WIDTH-1:0] srcA;
    logic [WORD_WIDTH-1:0] srcB;
    logic [WORD_WIDTH-1:0] imm;
    regAddrT               rs;
    regAddrT               rt;
    regAddrT               rd;
  } decExT;

  // Execute operand source, memory wins over writeback
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwdSelT;

endpackage

`default_nettype wire

//--- logic/controlDecoder.sv
/*
 * Main decoder
 * Turns the decode-stage instruction into datapath control, the ALU
 * operation and the branch and jump flags
 */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
  import isaPkg::*, pipePkg::*;
(
  input  instrWord instr,
  output ctrlT     ctrl,
  output logic     zeroExt,
  output logic     branch,
  output logic     branchNe,
  output logic     jump
);

  always_comb begin
    ctrl       = '0;            // Unknown opcodes fall out as a no-op
    ctrl.aluOp = ALU_ADD;
    zeroExt    = 1'b0;
    branch     = 1'b0;
    branchNe   = 1'b0;
    jump       = 1'b0;

    case (instr.rFields.op)
      OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (instr.rFields.funct)
          FN_ADD, FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUB, FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:          ctrl.aluOp = ALU_AND;
          FN_OR:           ctrl.aluOp = ALU_OR;
          FN_XOR:          ctrl.aluOp = ALU_XOR;
          FN_NOR:          ctrl.aluOp = ALU_NOR;
          FN_SLT:          ctrl.aluOp = ALU_SLT;
          FN_SLTU:         ctrl.aluOp = ALU_SLTU;
          default:         ctrl.regWrite = 1'b0;  // Shifts and the rest
        endcase
      end

      // ------------------------------
      // Memory and control flow
      // ------------------------------
      OP_LW: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      OP_BEQ: branch = 1'b1;
      OP_BNE: begin
        branch   = 1'b1;
        branchNe = 1'b1;
      end
      OP_J: jump = 1'b1;

      // Immediate arithmetic, opcode picks the operation
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        case (instr.iFields.op)
          OP_SLTI:  ctrl.aluOp = ALU_SLT;
          OP_SLTIU: ctrl.aluOp = ALU_SLTU;
          OP_ANDI:  ctrl.aluOp = ALU_AND;
          OP_ORI:   ctrl.aluOp = ALU_OR;
          OP_XORI:  ctrl.aluOp = ALU_XOR;
          default:  ctrl.aluOp = ALU_ADD;
        endcase
        zeroExt = (instr.iFields.op == OP_ANDI) || (instr.iFields.op == OP_ORI) ||
                  (instr.iFields.op == OP_XORI);  // Logical ops
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
/*
 * Hazard unit
 * Forwarding selects for decode and execute, plus the load-use and
 * branch stalls
 */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
  import isaPkg::*, pipePkg::*;
(
  input  regAddrT rsD,
  input  regAddrT rtD,
  input  regAddrT rsE,
  input  regAddrT rtE,
  input  regAddrT writeRegE,
  input  regAddrT writeRegM,
  input  regAddrT writeRegW,
  input  logic    regWriteE,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    memToRegE,
  input  logic    memToRegM,
  input  logic    branchD,
  output logic    forwardAD,
  output logic    forwardBD,
  output fwdSelT  forwardAE,
  output fwdSelT  forwardBE,
  output logic    stall,
  output logic    flushE
);

  logic loadUseStall;
  logic branchStall;

  // Branch compare operands from memory
  assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
  assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

  always_comb begin
    forwardAE = FWD_NONE;
    forwardBE = FWD_NONE;
    if (rsE != '0) begin
      if (regWriteM && (rsE == writeRegM))      forwardAE = FWD_MEM;
      else if (regWriteW && (rsE == writeRegW)) forwardAE = FWD_WB;
    end
    if (rtE != '0) begin
      if (regWriteM && (rtE == writeRegM))      forwardBE = FWD_MEM;
      else if (regWriteW && (rtE == writeRegW)) forwardBE = FWD_WB;
    end
  end

  // Load result not ready until writeback
  assign loadUseStall = memToRegE && ((rtE == rsD) || (rtE == rtD));

  // Branch operand still in execute, or a load still in memory
  assign branchStall = branchD &&
      ((regWriteE && (writeRegE != '0) && ((writeRegE == rsD) || (writeRegE == rtD))) ||
       (memToRegM && (writeRegM != '0) && ((writeRegM == rsD) || (writeRegM == rtD))));

  assign stall  = loadUseStall || branchStall;
  assign flushE = stall;  // Bubble into execute

endmodule

`default_nettype wire

//--- logic/regFile.sv
/*
 * Register file
 * Two combinational read ports and one write port on the falling edge,
 * register 0 reads as zero
 */
`timescale 1ns/1ps
`default_nettype none

module regFile
  import isaPkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  we,
  input  regAddrT               ra1,
  input  regAddrT               ra2,
  input  regAddrT               wa,
  input  logic [DATA_WIDTH-1:0] wd,
  output logic [DATA_WIDTH-1:0] rd1,
  output logic [DATA_WIDTH-1:0] rd2
);

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  // Falling edge write lets decode read the value in the same cycle
  always_ff @(negedge clk) begin
    if (we) regs[wa] <= wd;
  end

  assign rd1 = (ra1 != '0) ? regs[ra1] : '0;
  assign rd2 = (ra2 != '0) ? regs[ra2] : '0;

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
/*
 * Execute stage ALU
 * Forwarding muxes, immediate select and the integer operations
 */
`timescale 1ns/1ps
`default_nettype none

module aluUnit
  import isaPkg::*, pipePkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic [DATA_WIDTH-1:0] srcA,
  input  logic [DATA_WIDTH-1:0] srcB,
  input  logic [DATA_WIDTH-1:0] imm,
  input  logic [DATA_WIDTH-1:0] resultW,
  input  logic [DATA_WIDTH-1:0] aluOutM,
  input  fwdSelT                forwardA,
  input  fwdSelT                forwardB,
  input  logic                  aluSrc,
  input  aluOpT                 aluOp,
  output logic [DATA_WIDTH-1:0] aluResult,
  output logic [DATA_WIDTH-1:0] storeData
);

  localparam int MSB = DATA_WIDTH - 1;

  logic [DATA_WIDTH-1:0] opA, opB, bInv, sum;
  logic                  subtract, overflow, lessSigned, lessUnsigned;

  always_comb begin
    case (forwardA)
      FWD_MEM: opA = aluOutM;
      FWD_WB:  opA = resultW;
      default: opA = srcA;
    endcase
    case (forwardB)
      FWD_MEM: storeData = aluOutM;
      FWD_WB:  storeData = resultW;
      default: storeData = srcB;
    endcase
  end

  assign opB = aluSrc ? imm : storeData;

  // ------------------------------
  // Adder shared by ADD, SUB, SLT
  // ------------------------------
  assign subtract     = (aluOp == ALU_SUB) || (aluOp == ALU_SLT);
  assign bInv         = subtract ? ~opB : opB;
  assign sum          = opA + bInv + DATA_WIDTH'(subtract);  // Carry in
  assign overflow     = (opA[MSB] == bInv[MSB]) && (sum[MSB] != opA[MSB]);
  assign lessSigned   = sum[MSB] ^ overflow;
  assign lessUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      ALU_AND:  aluResult = opA & opB;
      ALU_OR:   aluResult = opA | opB;
      ALU_XOR:  aluResult = opA ^ opB;
      ALU_NOR:  aluResult = ~(opA | opB);
      ALU_SLT:  aluResult = DATA_WIDTH'(lessSigned);
      ALU_SLTU: aluResult = DATA_WIDTH'(lessUnsigned);
      default:  aluResult = sum;     // ADD and SUB
    endcase
  end

endmodule

`default_nettype wire

//--- logic/branchUnit.sv
/*
 * Decode-stage branch unit
 * Equality compare on forwarded operands and the redirect target for
 * BEQ, BNE and J
 */
`timescale 1ns/1ps
`default_nettype none

module branchUnit
  import isaPkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic [DATA_WIDTH-1:0] pcPlus4D,
  input  logic [DATA_WIDTH-1:0] regA,
  input  logic [DATA_WIDTH-1:0] regB,
  input  logic [DATA_WIDTH-1:0] aluOutM,
  input  logic                  forwardA,
  input  logic                  forwardB,
  input  instrWord              instr,
  input  logic                  branch,
  input  logic                  branchNe,
  input  logic                  jump,
  output logic                  pcSrc,
  output logic [DATA_WIDTH-1:0] pcTarget
);

  localparam int LOW_WIDTH = DATA_WIDTH - 4;

  logic [DATA_WIDTH-1:0] cmpA, cmpB, branchTarget, jumpTarget;
  logic                  equal;

  assign cmpA  = forwardA ? aluOutM : regA;
  assign cmpB  = forwardB ? aluOutM : regB;
  assign equal = (cmpA == cmpB);

  // Word offset, sign extended, relative to the delay slot
  assign branchTarget = pcPlus4D +
                        DATA_WIDTH'(signed'({instr.iFields.imm, 2'b00}));
  assign jumpTarget   = {pcPlus4D[DATA_WIDTH-1 -: 4],
                         LOW_WIDTH'({instr.jFields.target, 2'b00})};

  assign pcSrc    = jump || (branch && (equal ^ branchNe));
  assign pcTarget = jump ? jumpTarget : branchTarget;

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
/*
 * Five-stage pipelined MIPS core
 * PC, stage registers, immediate extension and writeback select,
 * with branches resolved in decode and one delay slot
 */
`timescale 1ns/1ps
`default_nettype none

module mipsCore
  import isaPkg::*, pipePkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  output logic [DATA_WIDTH-1:0] pc,
  input  instrWord              instr,
  output logic                  memWrite,
  output logic [DATA_WIDTH-1:0] aluOut,
  output logic [DATA_WIDTH-1:0] writeData,
  input  logic [DATA_WIDTH-1:0] readData
);

  logic [DATA_WIDTH-1:0] pcPlus4F, pcNextF, pcPlus4D, pcTargetD;
  logic [DATA_WIDTH-1:0] regAD, regBD, immD;
  logic [DATA_WIDTH-1:0] aluResultE, storeDataE;
  logic [DATA_WIDTH-1:0] aluOutM, writeDataM;
  logic [DATA_WIDTH-1:0] aluOutW, readDataW, resultW;
  instrWord              instrD;
  ctrlT                  ctrlD;
  decExT                 decExD, decExE;
  memCtrlT               memCtrlM;
  wbCtrlT                wbCtrlW;
  regAddrT               writeRegE, writeRegM, writeRegW;
  logic                  zeroExtD, branchD, branchNeD, jumpD, pcSrcD;
  logic                  forwardAD, forwardBD, stall, flushE;
  fwdSelT                forwardAE, forwardBE;

  // ------------------------------
  // Fetch
  // ------------------------------
  assign pcPlus4F = pc + DATA_WIDTH'(4);
  assign pcNextF  = pcSrcD ? pcTargetD : pcPlus4F;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)       pc <= '0;
    else if (!stall) pc <= pcNextF;
  end

  // Delay slot is never squashed, only held
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD   <= '0;
      pcPlus4D <= '0;
    end else if (!stall) begin
      instrD   <= instr;
      pcPlus4D <= pcPlus4F;
    end
  end

  // ------------------------------
  // Decode
  // ------------------------------
  controlDecoder u_dec (.instr(instrD), .ctrl(ctrlD), .zeroExt(zeroExtD),
                        .branch(branchD), .branchNe(branchNeD), .jump(jumpD));

  regFile #(.DATA_WIDTH(DATA_WIDTH)) u_rf (
    .clk(clk), .we(wbCtrlW.regWrite), .ra1(instrD.rFields.rs), .ra2(instrD.rFields.rt),
    .wa(writeRegW), .wd(resultW), .rd1(regAD), .rd2(regBD)
  );

  assign immD = zeroExtD ? DATA_WIDTH'(instrD.iFields.imm)
                         : DATA_WIDTH'(signed'(instrD.iFields.imm));

  branchUnit #(.DATA_WIDTH(DATA_WIDTH)) u_br (
    .pcPlus4D(pcPlus4D), .regA(regAD), .regB(regBD), .aluOutM(aluOutM),
    .forwardA(forwardAD), .forwardB(forwardBD), .instr(instrD), .branch(branchD),
    .branchNe(branchNeD), .jump(jumpD), .pcSrc(pcSrcD), .pcTarget(pcTargetD)
  );

  always_comb begin
    decExD.ctrl = ctrlD;
    decExD.srcA = WORD_WIDTH'(regAD);
    decExD.srcB = WORD_WIDTH'(regBD);
    decExD.imm  = WORD_WIDTH'(immD);
    decExD.rs   = instrD.rFields.rs;
    decExD.rt   = instrD.rFields.rt;
    decExD.rd   = instrD.rFields.rd;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)       decExE <= '0;
    else if (flushE) decExE <= '0;   // Bubble on stall
    else             decExE <= decExD;
  end

  // ------------------------------
  // Execute
  // ------------------------------
  aluUnit #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
    .srcA(DATA_WIDTH'(decExE.srcA)), .srcB(DATA_WIDTH'(decExE.srcB)),
    .imm(DATA_WIDTH'(decExE.imm)), .resultW(resultW), .aluOutM(aluOutM),
    .forwardA(forwardAE), .forwardB(forwardBE), .aluSrc(decExE.ctrl.aluSrc),
    .aluOp(decExE.ctrl.aluOp), .aluResult(aluResultE), .storeData(storeDataE)
  );

  assign writeRegE = decExE.ctrl.regDst ? decExE.rd : decExE.rt;

  hazardUnit u_haz (
    .rsD(instrD.rFields.rs), .rtD(instrD.rFields.rt), .rsE(decExE.rs), .rtE(decExE.rt),
    .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
    .regWriteE(decExE.ctrl.regWrite), .regWriteM(memCtrlM.regWrite),
    .regWriteW(wbCtrlW.regWrite), .memToRegE(decExE.ctrl.memToReg),
    .memToRegM(memCtrlM.memToReg), .branchD(branchD), .forwardAD(forwardAD),
    .forwardBD(forwardBD), .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stall(stall), .flushE(flushE)
  );

  // Memory stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      memCtrlM   <= '0;
      aluOutM    <= '0;
      writeDataM <= '0;
      writeRegM  <= '0;
    end else begin
      memCtrlM   <= '{regWrite: decExE.ctrl.regWrite, memWrite: decExE.ctrl.memWrite,
                      memToReg: decExE.ctrl.memToReg};
      aluOutM    <= aluResultE;
      writeDataM <= storeDataE;
      writeRegM  <= writeRegE;
    end
  end

  assign memWrite  = memCtrlM.memWrite;
  assign aluOut    = aluOutM;
  assign writeData = writeDataM;

  // Writeback stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbCtrlW   <= '0;
      aluOutW   <= '0;
      readDataW <= '0;
      writeRegW <= '0;
    end else begin
      wbCtrlW   <= '{regWrite: memCtrlM.regWrite, memToReg: memCtrlM.memToReg};
      aluOutW   <= aluOutM;
      readDataW <= readData;
      writeRegW <= writeRegM;
    end
  end

  assign resultW = wbCtrlW.memToReg ? readDataW : aluOutW;

endmodule

`default_nettype wire

//--- test/core_asserts.sv
/*
 * Core port assertions
 * Bound onto the core to watch fetch alignment and the store strobe
 */
`timescale 1ns/1ps
`default_nettype none

module coreAsserts #(
  parameter int DATA_WIDTH = 32
) (
  input logic                  clk,
  input logic                  reset,
  input logic [DATA_WIDTH-1:0] pc,
  input logic                  memWrite
);

  int failCount = 0;  // Tally of failed port checks

  // Fetch addresses are whole words
  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else begin
      failCount++;
      $error("pc %h is not word aligned", $sampled(pc));
    end

  // Stage registers clear asynchronously, no store while reset is high
  storeQuietInReset: assert property (@(posedge clk) reset |-> !memWrite)
    else begin
      failCount++;
      $error("memWrite high during reset");
    end

  storeStrobeKnown: assert property (@(posedge clk) !$isunknown(memWrite))
    else begin
      failCount++;
      $error("memWrite carries an unknown value");
    end

endmodule

`default_nettype wire

//--- test/mipsTb.sv
/*
 * Testbench for the pipelined MIPS core
 * Models instruction and data memory, runs a fixed program and checks
 * every store against values worked out by hand from MIPS semantics
 */
`timescale 1ns/1ps
`default_nettype none

module mipsTb
  import isaPkg::*;
();

  localparam int DATA_WIDTH       = 32;
  localparam int CLK_PERIOD       = 10;
  localparam int RESET_CYCLES     = 16;
  localparam int DRIVE_DELAY      = 1;
  localparam int CYCLES_PER_INSTR = 50;
  localparam int IMEM_WORDS       = 128;
  localparam int DMEM_WORDS       = 64;

  logic                  clk;
  logic                  reset;
  logic [DATA_WIDTH-1:0] pc;
  instrWord              instr;
  logic                  memWrite;
  logic [DATA_WIDTH-1:0] aluOut;
  logic [DATA_WIDTH-1:0] writeData;
  logic [DATA_WIDTH-1:0] readData;

  logic [31:0]           imem [IMEM_WORDS];
  logic [DATA_WIDTH-1:0] dmem [DMEM_WORDS];
  logic [DATA_WIDTH-1:0] expData [DMEM_WORDS];  // Expected store value per word
  logic                  expValid [DMEM_WORDS];
  int                    writeCount [DMEM_WORDS];
  int                    progLen = 0;
  int                    expCount = 0;
  int                    errors = 0;
  bit                    programReady = 1'b0;

  mipsCore #(.DATA_WIDTH(DATA_WIDTH)) dut0 (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .memWrite(memWrite),
    .aluOut(aluOut), .writeData(writeData), .readData(readData)
  );

  bind mipsCore coreAsserts #(.DATA_WIDTH(DATA_WIDTH)) coreChecks (
    .clk(clk), .reset(reset), .pc(pc), .memWrite(memWrite)
  );

  // ------------------------------
  // Memory models
  // ------------------------------
  assign instr    = imem[pc[8:2]];
  assign readData = dmem[aluOut[7:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[aluOut[7:2]]       <= writeData;
      writeCount[aluOut[7:2]] <= writeCount[aluOut[7:2]] + 1;
    end
  end

  // ------------------------------
  // Program builder
  // ------------------------------
  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic rOp(input functT fn, input int rd, input int rs, input int rt);
    emit({OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
  endtask

  task automatic iOp(input opcodeT op, input int rt, input int rs, input logic [15:0] imm);
    emit({op, 5'(rs), 5'(rt), imm});
  endtask

  // SW off $0 with the value it must carry
  task automatic storeChecked(input int rt, input logic [7:0] addr, input logic [31:0] value);
    iOp(OP_SW, rt, 0, {8'h00, addr});
    expData[addr[7:2]]  = value;
    expValid[addr[7:2]] = 1'b1;
    expCount++;
  endtask

  task automatic jumpTo(input int index);
    emit({OP_J, 26'(index)});
  endtask

  task automatic clearMemories();
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = '0;  // All NOP
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]       <= '0;
      expData[i]    = '0;
      expValid[i]   = 1'b0;
      writeCount[i] <= 0;
    end
  endtask

  task automatic loadProgram();
    iOp(OP_ADDI, 1, 0, 16'd100);                   // $1 = 100
    iOp(OP_ADDI, 2, 0, 16'hFFF9);                  // $2 = -7
    iOp(OP_ORI, 3, 0, 16'hF0F0);
    // Each R-type result stored right away
    rOp(FN_ADD, 4, 1, 2);
    storeChecked(4, 8'h00, 32'h0000_005D);
    rOp(FN_ADDU, 4, 2, 3);
    storeChecked(4, 8'h04, 32'h0000_F0E9);
    rOp(FN_SUB, 4, 1, 2);
    storeChecked(4, 8'h08, 32'h0000_006B);
    rOp(FN_SUBU, 4, 2, 1);
    storeChecked(4, 8'h0C, 32'hFFFF_FF95);
    rOp(FN_AND, 4, 2, 3);
    storeChecked(4, 8'h10, 32'h0000_F0F0);
    rOp(FN_OR, 4, 1, 3);
    storeChecked(4, 8'h14, 32'h0000_F0F4);
    rOp(FN_XOR, 4, 2, 3);
    storeChecked(4, 8'h18, 32'hFFFF_0F09);
    rOp(FN_NOR, 4, 1, 3);
    storeChecked(4, 8'h1C, 32'hFFFF_0F0B);
    rOp(FN_SLT, 4, 2, 1);
    storeChecked(4, 8'h20, 32'h0000_0001);
    rOp(FN_SLTU, 4, 2, 1);
    storeChecked(4, 8'h24, 32'h0000_0000);
    // Immediates with the logical ones zero extended
    iOp(OP_ADDI, 5, 1, 16'hFF38);
    storeChecked(5, 8'h28, 32'hFFFF_FF9C);
    iOp(OP_ADDIU, 5, 2, 16'h0010);
    storeChecked(5, 8'h2C, 32'h0000_0009);
    iOp(OP_SLTI, 5, 2, 16'hFFFB);
    storeChecked(5, 8'h30, 32'h0000_0001);
    iOp(OP_SLTIU, 5, 1, 16'hFFFF);
    storeChecked(5, 8'h34, 32'h0000_0001);
    iOp(OP_ANDI, 5, 2, 16'h00FF);
    storeChecked(5, 8'h38, 32'h0000_00F9);
    iOp(OP_ORI, 5, 1, 16'h8000);
    storeChecked(5, 8'h3C, 32'h0000_8064);
    iOp(OP_XORI, 5, 2, 16'hFFFF);
    storeChecked(5, 8'h40, 32'hFFFF_0006);
    // Forwarding at distance 1 and 2
    rOp(FN_ADD, 6, 1, 1);
    rOp(FN_ADD, 7, 6, 1);
    rOp(FN_SUB, 8, 7, 6);
    storeChecked(7, 8'h48, 32'h0000_012C);
    storeChecked(8, 8'h44, 32'h0000_0064);
    // Load-use bubble
    iOp(OP_LW, 9, 0, 16'h0048);
    rOp(FN_ADD, 10, 9, 1);
    storeChecked(10, 8'h4C, 32'h0000_0190);
    // BEQ not taken on an operand from the instruction just before
    iOp(OP_ADDI, 11, 0, 16'd5);
    iOp(OP_BEQ, 1, 11, 16'd2);
    storeChecked(11, 8'h50, 32'h0000_0005);        // Delay slot
    storeChecked(1, 8'h54, 32'h0000_0064);
    // BEQ taken
    iOp(OP_ADDI, 12, 0, 16'd100);
    iOp(OP_BEQ, 1, 12, 16'd2);
    storeChecked(12, 8'h58, 32'h0000_0064);
    iOp(OP_SW, 12, 0, 16'h005C);                   // Skipped
    // BNE not taken, then taken
    iOp(OP_XORI, 13, 1, 16'h0064);
    iOp(OP_BNE, 0, 13, 16'd2);
    storeChecked(1, 8'h60, 32'h0000_0064);
    storeChecked(2, 8'h64, 32'hFFFF_FFF9);
    iOp(OP_ADDI, 14, 0, 16'd3);
    iOp(OP_BNE, 0, 14, 16'd2);
    storeChecked(14, 8'h68, 32'h0000_0003);
    iOp(OP_SW, 14, 0, 16'h006C);                   // Skipped
    // Jump over one store, then park
    jumpTo(64);
    storeChecked(1, 8'h70, 32'h0000_0064);
    iOp(OP_SW, 1, 0, 16'h0074);                    // Skipped
    storeChecked(2, 8'h78, 32'hFFFF_FFF9);
    jumpTo(65);                                    // Self loop with a NOP in its delay slot
    progLen++;
  endtask

  function automatic int storesSeen();
    int seen;
    seen = 0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      if (expValid[i] && writeCount[i] > 0) seen++;
    end
    return seen;
  endfunction

  task automatic checkStoreCounts();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      if (expValid[i] && writeCount[i] != 1) begin
        errors++;
        $display("store to address %h happened %0d times instead of once", i * 4,
                 writeCount[i]);
      end
    end
  endtask

  // ------------------------------
  // Store checks
  // ------------------------------
  storeValue: assert property (@(posedge clk) disable iff (reset)
      memWrite && expValid[aluOut[7:2]] |-> writeData == expData[aluOut[7:2]])
    else begin
      errors++;
      $display("CHECK FAILED writeData at address %h: expected %h, got %h", $sampled(aluOut),
               expData[$sampled(aluOut[7:2])], $sampled(writeData));
    end

  storeAddress: assert property (@(posedge clk) disable iff (reset)
      memWrite |-> aluOut[31:8] == '0 && expValid[aluOut[7:2]])
    else begin
      errors++;
      $display("store to address %h, which is on a skipped path or not expected",
               $sampled(aluOut));
    end

  storeOnce: assert property (@(posedge clk) disable iff (reset)
      memWrite && expValid[aluOut[7:2]] |-> writeCount[aluOut[7:2]] == 0)
    else begin
      errors++;
      $display("second store to address %h", $sampled(aluOut));
    end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    int coreFails;
    reset = 1'b1;
    clearMemories();
    loadProgram();
    programReady = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY reset = 1'b0;
    while (storesSeen() < expCount) @(negedge clk);
    repeat (8) @(negedge clk);  // Room for a stray late store
    checkStoreCounts();
    coreFails = dut0.coreChecks.failCount;
    $display("Errors: %0d store checks, %0d core port checks", errors, coreFails);
    if (errors == 0 && coreFails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog scaled by program length
  initial begin
    wait (programReady);
    #((progLen * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d expected stores seen", storesSeen(), expCount);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/controlDecoder.sv
logic/hazardUnit.sv
logic/regFile.sv
logic/aluUnit.sv
logic/branchUnit.sv
logic/mipsCore.sv
test/core_asserts.sv
test/mipsTb.sv

//--- Makefile
# Verilator build and run for the pipelined MIPS core

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsTb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
